/* src/icache_geom_pkg.sv */
package icache_geom_pkg;

  // address and instruction width
  localparam int xlen = 32;

  // 16 words per line, 8 lines
  localparam int line_words_log2 = 4;
  localparam int line_count_log2 = 3;
  localparam int line_count      = 1 << line_count_log2;

  // line_ram address is {line, word}
  localparam int cache_addr_w = line_count_log2 + line_words_log2;

  // everything above the word and byte offsets
  localparam int tag_w = xlen - line_words_log2 - 2;

  // one fetch address, read as lookup fields or as a bus word address
  typedef union packed {
    struct packed {
      logic [tag_w-1:0]           tag;
      logic [line_words_log2-1:0] word;
      logic [1:0]                 byte_off;
    } fields;
    struct packed {
      logic [xlen-3:0] word_adr;
      logic [1:0]      byte_off;
    } bus;
  } fetch_addr_u;

endpackage

/* src/wb_bus_pkg.sv */
package wb_bus_pkg;

  // word addressed master port, 32-bit data
  localparam int wb_adr_w = 30;
  localparam int wb_dat_w = 32;
  localparam int wb_sel_w = 4;

  // instruction reads always take the full word
  localparam logic [wb_sel_w-1:0] wb_sel_all = 4'b1111;

  // refill master sequencing
  localparam logic [1:0] refill_idle = 2'd0;
  localparam logic [1:0] refill_arb  = 2'd1;
  localparam logic [1:0] refill_read = 2'd2;
  localparam logic [1:0] refill_done = 2'd3;

endpackage

/* src/fetch_request.sv */
`timescale 1ns/100ps

module fetch_request (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  logic                                          advance_i,
  input  icache_geom_pkg::fetch_addr_u                  addr_i,
  input  logic                                          hit_i,
  input  logic [icache_geom_pkg::line_count_log2-1:0]   hit_line_i,
  input  logic                                          refill_done_i,
  input  logic                                          refill_err_i,
  output logic [icache_geom_pkg::tag_w-1:0]             lookup_tag_o,
  output logic                                          rd_en_o,
  output logic [icache_geom_pkg::cache_addr_w-1:0]      rd_addr_o,
  output logic                                          refill_start_o,
  output icache_geom_pkg::fetch_addr_u                  miss_addr_o,
  output logic                                          busy_o,
  output logic                                          error_o
);

  logic aligned;
  logic accept;

  assign aligned = (addr_i.fields.byte_off == 2'b00);
  assign accept  = advance_i & ~busy_o & aligned; // a strobe during refill is dropped

  assign lookup_tag_o = addr_i.fields.tag;
  assign rd_addr_o    = {hit_line_i, addr_i.fields.word};
  assign rd_en_o      = accept & hit_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_o         <= 1'b0;
      error_o        <= 1'b0;
      refill_start_o <= 1'b0;
    end else begin
      refill_start_o <= 1'b0;
      error_o        <= refill_err_i; // bus error ends the miss with a pulse
      if (busy_o) begin
        if (refill_done_i | refill_err_i)
          busy_o <= 1'b0;
      end else if (advance_i) begin
        if (!aligned) begin
          error_o <= 1'b1;
        end else if (!hit_i) begin
          busy_o         <= 1'b1;
          refill_start_o <= 1'b1;
        end
      end
    end
  end

  // held for the whole refill
  always_ff @(posedge clk_i) begin
    if (accept && !hit_i)
      miss_addr_o <= addr_i;
  end

endmodule

/* src/tag_directory.sv */
`timescale 1ns/100ps

module tag_directory (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic [icache_geom_pkg::tag_w-1:0]           lookup_tag_i,
  output logic                                        hit_o,
  output logic [icache_geom_pkg::line_count_log2-1:0] hit_line_o,
  output logic [icache_geom_pkg::line_count_log2-1:0] victim_line_o,
  input  logic [icache_geom_pkg::tag_w-1:0]           miss_tag_i,
  input  logic                                        fill_i
);

  logic [icache_geom_pkg::tag_w-1:0]           tags [icache_geom_pkg::line_count];
  logic [icache_geom_pkg::line_count-1:0]      valid;
  logic [icache_geom_pkg::line_count_log2-1:0] rr_ptr;

  // fully associative match, all lines at once
  always_comb begin
    hit_o      = 1'b0;
    hit_line_o = '0;
    for (int i = 0; i < icache_geom_pkg::line_count; i++) begin
      if (valid[i] && (tags[i] == lookup_tag_i)) begin
        hit_o      = 1'b1;
        hit_line_o = i[icache_geom_pkg::line_count_log2-1:0];
      end
    end
  end

  assign victim_line_o = rr_ptr;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid  <= '0;
      rr_ptr <= '0;
    end else if (fill_i) begin
      valid[rr_ptr] <= 1'b1;
      rr_ptr        <= rr_ptr + 1'b1; // oldest fill is replaced next
    end
  end

  // tag store
  always_ff @(posedge clk_i) begin
    if (fill_i)
      tags[rr_ptr] <= miss_tag_i;
  end

endmodule

/* src/line_ram.sv */
`timescale 1ns/100ps

module line_ram (
  input  logic                                     clk_i,
  input  logic                                     wr_en_i,
  input  logic [icache_geom_pkg::cache_addr_w-1:0] wr_addr_i,
  input  logic [icache_geom_pkg::xlen-1:0]         wr_data_i,
  input  logic                                     rd_en_i,
  input  logic [icache_geom_pkg::cache_addr_w-1:0] rd_addr_i,
  output logic [icache_geom_pkg::xlen-1:0]         rd_data_o
);

  logic [icache_geom_pkg::xlen-1:0] mem [1 << icache_geom_pkg::cache_addr_w];

  always_ff @(posedge clk_i) begin
    if (wr_en_i)
      mem[wr_addr_i] <= wr_data_i;
    // output holds between accepted lookups
    if (rd_en_i)
      rd_data_o <= mem[rd_addr_i];
  end

endmodule

/* src/line_refill.sv */
`timescale 1ns/100ps

module line_refill (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic                                        start_i,
  input  icache_geom_pkg::fetch_addr_u                miss_addr_i,
  input  logic [icache_geom_pkg::line_count_log2-1:0] victim_line_i,
  input  logic                                        ctrl_grant_i,
  input  logic                                        ack_i,
  input  logic                                        err_i,
  input  logic [wb_bus_pkg::wb_dat_w-1:0]             dat_i,
  output logic                                        ctrl_req_o,
  output logic [wb_bus_pkg::wb_adr_w-1:0]             adr_o,
  output logic                                        cyc_o,
  output logic                                        stb_o,
  output logic [wb_bus_pkg::wb_sel_w-1:0]             sel_o,
  output logic                                        wr_en_o,
  output logic [icache_geom_pkg::cache_addr_w-1:0]    wr_addr_o,
  output logic [icache_geom_pkg::xlen-1:0]            wr_data_o,
  output logic                                        done_o,
  output logic                                        err_o
);

  logic [1:0]                                 state;
  logic [icache_geom_pkg::line_words_log2:0]  word_cnt; // msb set once the line is complete
  logic [icache_geom_pkg::line_words_log2:0]  word_cnt_nxt;
  logic [icache_geom_pkg::line_words_log2-1:0] word;

  assign word_cnt_nxt = word_cnt + 1'b1;
  assign word         = word_cnt[icache_geom_pkg::line_words_log2-1:0];

  // line base from the missed address, word offset from the counter
  assign adr_o = {miss_addr_i.bus.word_adr[wb_bus_pkg::wb_adr_w-1:icache_geom_pkg::line_words_log2],
                  word};
  assign sel_o = wb_bus_pkg::wb_sel_all;
  assign cyc_o = stb_o;

  assign wr_en_o   = stb_o & ack_i;
  assign wr_addr_o = {victim_line_i, word};
  assign wr_data_o = dat_i;

  assign done_o = (state == wb_bus_pkg::refill_done);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state      <= wb_bus_pkg::refill_idle;
      word_cnt   <= '0;
      ctrl_req_o <= 1'b0;
      stb_o      <= 1'b0;
      err_o      <= 1'b0;
    end else begin
      err_o <= 1'b0;
      case (state)
        wb_bus_pkg::refill_arb: begin
          if (ctrl_grant_i) begin
            state <= wb_bus_pkg::refill_read;
            stb_o <= 1'b1;
          end
        end
        wb_bus_pkg::refill_read: begin
          if (ack_i) begin
            word_cnt <= word_cnt_nxt;
            if (word_cnt_nxt[icache_geom_pkg::line_words_log2]) begin
              state      <= wb_bus_pkg::refill_done;
              stb_o      <= 1'b0;
              ctrl_req_o <= 1'b0;
            end
          end else if (err_i) begin
            // abandon the line, it stays invalid
            state      <= wb_bus_pkg::refill_idle;
            stb_o      <= 1'b0;
            ctrl_req_o <= 1'b0;
            err_o      <= 1'b1;
          end
        end
        wb_bus_pkg::refill_done: begin
          state <= wb_bus_pkg::refill_idle;
        end
        default: begin
          if (start_i) begin
            state      <= wb_bus_pkg::refill_arb;
            word_cnt   <= '0;
            ctrl_req_o <= 1'b1; // held until the line is finished
          end
        end
      endcase
    end
  end

endmodule

/* src/icache_top.sv */
`timescale 1ns/100ps

module icache_top (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                advance_i,
  input  logic [icache_geom_pkg::xlen-1:0]    addr_i,
  output logic                                busy_o,
  output logic [icache_geom_pkg::xlen-1:0]    instruction_o,
  output logic                                error_o,
  output logic                                ctrl_req_o,
  input  logic                                ctrl_grant_i,
  output logic [wb_bus_pkg::wb_adr_w-1:0]     adr_o,
  output logic                                cyc_o,
  output logic                                stb_o,
  output logic [wb_bus_pkg::wb_sel_w-1:0]     sel_o,
  input  logic [wb_bus_pkg::wb_dat_w-1:0]     dat_i,
  input  logic                                ack_i,
  input  logic                                err_i
);

  logic [icache_geom_pkg::tag_w-1:0]           lookup_tag;
  logic                                        hit;
  logic [icache_geom_pkg::line_count_log2-1:0] hit_line;
  logic [icache_geom_pkg::line_count_log2-1:0] victim_line;
  logic                                        rd_en;
  logic [icache_geom_pkg::cache_addr_w-1:0]    rd_addr;
  logic                                        refill_start;
  icache_geom_pkg::fetch_addr_u                miss_addr;
  logic                                        refill_done;
  logic                                        refill_err;
  logic                                        wr_en;
  logic [icache_geom_pkg::cache_addr_w-1:0]    wr_addr;
  logic [icache_geom_pkg::xlen-1:0]            wr_data;

  fetch_request u_fetch_request (
    .clk_i(clk_i), .reset_i(reset_i), .advance_i(advance_i), .addr_i(addr_i),
    .hit_i(hit), .hit_line_i(hit_line),
    .refill_done_i(refill_done), .refill_err_i(refill_err),
    .lookup_tag_o(lookup_tag), .rd_en_o(rd_en), .rd_addr_o(rd_addr),
    .refill_start_o(refill_start), .miss_addr_o(miss_addr),
    .busy_o(busy_o), .error_o(error_o)
  );

  tag_directory u_tag_directory (
    .clk_i(clk_i), .reset_i(reset_i), .lookup_tag_i(lookup_tag),
    .hit_o(hit), .hit_line_o(hit_line), .victim_line_o(victim_line),
    .miss_tag_i(miss_addr.fields.tag), .fill_i(refill_done)
  );

  line_ram u_line_ram (
    .clk_i(clk_i), .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
    .rd_en_i(rd_en), .rd_addr_i(rd_addr), .rd_data_o(instruction_o)
  );

  line_refill u_line_refill (
    .clk_i(clk_i), .reset_i(reset_i), .start_i(refill_start),
    .miss_addr_i(miss_addr), .victim_line_i(victim_line),
    .ctrl_grant_i(ctrl_grant_i), .ack_i(ack_i), .err_i(err_i), .dat_i(dat_i),
    .ctrl_req_o(ctrl_req_o), .adr_o(adr_o), .cyc_o(cyc_o), .stb_o(stb_o), .sel_o(sel_o),
    .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
    .done_o(refill_done), .err_o(refill_err)
  );

endmodule

/* tb/icache_sva.sv */
`timescale 1ns/100ps

module icache_sva (
  input logic                            clk_i,
  input logic                            reset_i,
  input logic [1:0]                      state_i,
  input logic                            start_i,
  input logic                            ctrl_req_i,
  input logic                            cyc_i,
  input logic                            stb_i,
  input logic                            ack_i,
  input logic [wb_bus_pkg::wb_adr_w-1:0] adr_i
);

  // a strobe only inside an open, requested cycle
  stb_in_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    stb_i |-> (cyc_i && ctrl_req_i))
    else $error("stb_o seen without cyc_o and ctrl_req_o");

  // master holds the address until the slave answers
  adr_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (stb_i && !ack_i) |=> $stable(adr_i))
    else $error("adr_o changed while a strobe was waiting for ack_i");

  reset_quiet: assert property (@(posedge clk_i)
    reset_i |=> (!stb_i && !ctrl_req_i))
    else $error("bus active right after reset");

  // no bus activity until a refill is started
  idle_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_i == wb_bus_pkg::refill_idle && !start_i) |=> (!stb_i && !ctrl_req_i))
    else $error("refill master left idle without start_i");

endmodule

bind line_refill icache_sva u_icache_sva (
  .clk_i(clk_i), .reset_i(reset_i), .state_i(state), .start_i(start_i),
  .ctrl_req_i(ctrl_req_o), .cyc_i(cyc_o), .stb_i(stb_o), .ack_i(ack_i), .adr_i(adr_o)
);

/* tb/icache_tb.sv */
`timescale 1ns/100ps

module icache_tb;

  typedef enum logic [1:0] {k_hit, k_miss, k_misalign, k_buserr} kind_e;
  typedef struct packed {
    logic [31:0] addr;
    kind_e       kind;
    logic [3:0]  inj_word; // word that answers with err_i on a bus error row
  } row_t;

  localparam int n_rows       = 19;
  localparam int refill_limit = 300; // cycles

  logic                                clk_i;
  logic                                reset_i      = 1'b1;
  logic                                advance_i    = 1'b0;
  logic [icache_geom_pkg::xlen-1:0]    addr_i       = '0;
  logic                                ctrl_grant_i = 1'b0;
  logic [wb_bus_pkg::wb_dat_w-1:0]     dat_i        = '0;
  logic                                ack_i        = 1'b0;
  logic                                err_i        = 1'b0;
  logic                                busy_o;
  logic [icache_geom_pkg::xlen-1:0]    instruction_o;
  logic                                error_o;
  logic                                ctrl_req_o;
  logic [wb_bus_pkg::wb_adr_w-1:0]     adr_o;
  logic                                cyc_o;
  logic                                stb_o;
  logic [wb_bus_pkg::wb_sel_w-1:0]     sel_o;

  row_t                                rows [n_rows];
  int                                  seed       = 33;
  int                                  ack_wait   = 0;
  int                                  grant_wait = 0;
  int                                  xfer_total = 0;
  int                                  stb_total  = 0;
  int                                  xfer_mark  = 0;
  logic [wb_bus_pkg::wb_adr_w-1:0]     exp_base   = '0;
  logic                                inj_en     = 1'b0;
  logic [3:0]                          inj_word   = '0;

  icache_top uut (
    .clk_i(clk_i), .reset_i(reset_i), .advance_i(advance_i), .addr_i(addr_i),
    .busy_o(busy_o), .instruction_o(instruction_o), .error_o(error_o),
    .ctrl_req_o(ctrl_req_o), .ctrl_grant_i(ctrl_grant_i),
    .adr_o(adr_o), .cyc_o(cyc_o), .stb_o(stb_o), .sel_o(sel_o),
    .dat_i(dat_i), .ack_i(ack_i), .err_i(err_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // memory contents as seen on the bus
  function automatic logic [31:0] mem_word(input logic [29:0] word_adr);
    return {2'b00, word_adr} ^ 32'hA5A5_0000;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [icache_geom_pkg::xlen-1:0] got,
                            input logic [icache_geom_pkg::xlen-1:0] exp);
    if (got !== exp)
      fail_run($sformatf("** Error %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("** Error %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_adr(input string name, input logic [wb_bus_pkg::wb_adr_w-1:0] got,
                           input logic [wb_bus_pkg::wb_adr_w-1:0] exp);
    if (got !== exp)
      fail_run($sformatf("** Error %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_sel(input string name, input logic [wb_bus_pkg::wb_sel_w-1:0] got,
                           input logic [wb_bus_pkg::wb_sel_w-1:0] exp);
    if (got !== exp)
      fail_run($sformatf("** Error %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // arbiter and memory slave models
  always @(posedge clk_i) begin
    ack_i <= 1'b0;
    err_i <= 1'b0;
    if (!ctrl_req_o) begin
      ctrl_grant_i <= 1'b0;
    end else if (!ctrl_grant_i) begin
      if (grant_wait != 0) begin
        grant_wait <= grant_wait - 1;
      end else begin
        ctrl_grant_i <= 1'b1;
        grant_wait   <= {$random(seed)} % 5;
      end
    end
    if (stb_o && !ack_i && !err_i) begin
      if (ack_wait != 0) begin
        ack_wait <= ack_wait - 1; // slave back-pressure
      end else begin
        ack_wait <= {$random(seed)} % 4;
        if (inj_en && adr_o[3:0] == inj_word)
          err_i <= 1'b1;
        else begin
          ack_i <= 1'b1;
          dat_i <= mem_word(adr_o);
        end
      end
    end
  end

  // each acked beat must walk up from the line base
  always @(posedge clk_i) begin
    if (stb_o) begin
      stb_total <= stb_total + 1;
      check_sel("sel_o", sel_o, 4'b1111); // instruction reads take all four bytes
    end
    if (stb_o && ack_i) begin
      check_adr("adr_o", adr_o, exp_base + 30'(xfer_total - xfer_mark));
      xfer_total <= xfer_total + 1;
    end
  end

  // one advance strobe that returns at the negedge after the lookup edge
  task automatic issue(input logic [31:0] addr);
    @(posedge clk_i);
    advance_i <= 1'b1;
    addr_i    <= addr;
    @(posedge clk_i);
    advance_i <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic wait_busy_low(input int limit);
    int n;
    n = 0;
    while (busy_o !== 1'b0 && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    if (busy_o !== 1'b0)
      fail_run($sformatf("busy_o still high after %0d cycles of refill", limit));
  endtask

  task automatic apply_row(input row_t row);
    int stb_mark;
    stb_mark  = stb_total;
    xfer_mark = xfer_total;
    exp_base  = {row.addr[31:6], 4'b0000};
    inj_word  = row.inj_word;
    inj_en    = (row.kind == k_buserr);
    issue(row.addr);
    case (row.kind)
      k_hit: begin
        check_flag("busy_o", busy_o, 1'b0);
        check_word("instruction_o", instruction_o, mem_word(row.addr[31:2]));
      end
      k_misalign: begin
        check_flag("error_o", error_o, 1'b1);
        check_flag("busy_o", busy_o, 1'b0);
        @(negedge clk_i);
        check_flag("error_o", error_o, 1'b0);
      end
      k_buserr: begin
        check_flag("busy_o", busy_o, 1'b1);
        wait_busy_low(refill_limit);
        check_flag("error_o", error_o, 1'b1); // pulse comes with the fall of busy
        check_flag("ctrl_req_o", ctrl_req_o, 1'b0);
        @(negedge clk_i);
        check_flag("error_o", error_o, 1'b0);
      end
      default: begin
        check_flag("busy_o", busy_o, 1'b1);
        check_flag("error_o", error_o, 1'b0);
        wait_busy_low(refill_limit);
        check_flag("error_o", error_o, 1'b0);
        check_flag("ctrl_req_o", ctrl_req_o, 1'b0);
        if (xfer_total - xfer_mark != 16)
          fail_run($sformatf("refill made %0d acked transfers instead of 16",
                             xfer_total - xfer_mark));
        stb_mark = stb_total;
        issue(row.addr); // same address again, now a hit
        check_flag("busy_o", busy_o, 1'b0);
        check_word("instruction_o", instruction_o, mem_word(row.addr[31:2]));
      end
    endcase
    @(negedge clk_i);
    check_flag("stb_o", stb_o, 1'b0);
    if (row.kind != k_buserr && stb_total != stb_mark)
      fail_run("bus strobe seen on a request that needed no refill");
    inj_en = 1'b0;
  endtask

  initial begin
    rows = '{
      '{32'h0000_1000, k_miss,     4'd0},
      '{32'h0000_1004, k_hit,      4'd0},
      '{32'h0000_103C, k_hit,      4'd0},
      '{32'h0000_1002, k_misalign, 4'd0},
      '{32'h0000_2040, k_buserr,   4'd5},
      '{32'h0000_2040, k_miss,     4'd0}, // retry after the bus error
      '{32'h0000_2078, k_hit,      4'd0},
      '{32'h0000_3000, k_miss,     4'd0},
      '{32'h0000_4000, k_miss,     4'd0},
      '{32'h0000_5000, k_miss,     4'd0},
      '{32'h0000_6000, k_miss,     4'd0},
      '{32'h0000_7000, k_miss,     4'd0},
      '{32'h0000_8000, k_miss,     4'd0},
      '{32'h0000_1010, k_hit,      4'd0}, // all eight lines still held
      '{32'h0000_9000, k_miss,     4'd0}, // ninth line evicts the first
      '{32'h0000_9010, k_hit,      4'd0},
      '{32'h0000_1000, k_miss,     4'd0},
      '{32'h0000_1020, k_hit,      4'd0},
      '{32'h0000_9003, k_misalign, 4'd0}
    };
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("error_o", error_o, 1'b0);
    check_flag("ctrl_req_o", ctrl_req_o, 1'b0);
    check_flag("cyc_o", cyc_o, 1'b0);
    check_flag("stb_o", stb_o, 1'b0);
    for (int r = 0; r < n_rows; r++)
      apply_row(rows[r]);
    $display("Regression passed");
    $finish;
  end

endmodule

/* icache.f */
src/icache_geom_pkg.sv
src/wb_bus_pkg.sv
src/fetch_request.sv
src/tag_directory.sv
src/line_ram.sv
src/line_refill.sv
src/icache_top.sv
tb/icache_sva.sv
tb/icache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the icache testbench with Verilator and run it
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module icache_tb -f icache.f \
  --Mdir obj_dir -o icache_sim \
  && ./obj_dir/icache_sim \
  || { echo "icache simulation did not complete cleanly"; exit 1; }
